// File: project.f
+incdir+design
design/move_gen_pkg.sv
design/move_fifo.sv
design/column_scanner.sv
design/move_collector.sv
design/move_gen_top.sv
tb/move_gen_sva.sv
tb/move_gen_tb.sv

// File: Bender.yml
package:
  name: move_gen

sources:
  - include_dirs:
      - design
    files:
      - design/move_gen_pkg.sv
      - design/move_fifo.sv
      - design/column_scanner.sv
      - design/move_collector.sv
      - design/move_gen_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/move_gen_sva.sv
      - tb/move_gen_tb.sv

// File: tb/move_gen_tb.sv
`include "move_gen_consts.svh"

module move_gen_tb import move_gen_pkg::*; ();

	localparam int n_random = 6;
	localparam int n_entries = 6 + n_random;
	localparam int cycle_limit = n_entries * 2000;
	localparam int pause_cycles = 200;
	localparam logic [2:0] pc_pawn = 3'd1;
	localparam logic [2:0] pc_knight = 3'd2;
	localparam logic [2:0] pc_king = 3'd6;

	typedef struct packed {
		board_t board;
		logic black;
		logic [31:0] count;
		logic [31:0] sum;
	} entry_t;

	logic clk;
	logic reset;
	board_t board;
	logic black_to_move;
	logic start;
	logic rden;
	move_t move_out;
	logic move_valid;
	logic done;

	entry_t table_q[$];
	string names_q[$];
	logic [31:0] seed;

	move_gen_top i_move_gen_top (
		.clk(clk),
		.reset(reset),
		.board(board),
		.black_to_move(black_to_move),
		.start(start),
		.move_out(move_out),
		.move_valid(move_valid),
		.rden(rden),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	initial begin
		repeat (cycle_limit) @(posedge clk);
		fail_run($sformatf("timeout, collection did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		wait (i_move_gen_top.i_sva.fail_count != 0);
		fail_run("a bound assertion on the DUT failed");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// slide up then down the file until the first occupied square
	function automatic void model(input board_t b, input logic side,
			output logic [31:0] count, output logic [31:0] sum);
		piece_t p;
		piece_t q;
		move_t m;
		int t;
		int dir;
		logic stop;
		count = 0;
		sum = 0;
		for (int f = 0; f < `FILES; f++) begin
			for (int r = 0; r < `RANKS; r++) begin
				p = b[r * `FILES + f];
				if (p.black == side && (p.kind == `PC_ROOK || p.kind == `PC_QUEEN)) begin
					for (int d = 0; d < 2; d++) begin
						dir = (d == 0) ? 1 : -1;
						t = r + dir;
						stop = 1'b0;
						while (!stop && t >= 0 && t < `RANKS) begin
							q = b[t * `FILES + f];
							stop = q.kind != `PC_EMPTY;
							if (q.kind == `PC_EMPTY || q.black != side) begin
								m = '0;
								m.flags.capture = q.kind != `PC_EMPTY;
								m.from.rank = 3'(r);
								m.from.file = 3'(f);
								m.to.rank = 3'(t);
								m.to.file = 3'(f);
								count++;
								sum += 32'(m);
							end
							t += dir;
						end
					end
				end
			end
		end
	endfunction

	// half the squares empty and most others sliders of both colours
	function automatic board_t random_board();
		board_t b;
		for (int n = 0; n < `RANKS * `FILES; n++) begin
			seed = xorshift(seed);
			b[n].black = seed[8];
			if (seed[3:0] < 4'd8)
				b[n].kind = `PC_EMPTY;
			else if (seed[3:0] < 4'd11)
				b[n].kind = `PC_ROOK;
			else if (seed[3:0] < 4'd13)
				b[n].kind = `PC_QUEEN;
			else
				b[n].kind = pc_pawn;
		end
		return b;
	endfunction

	task automatic add_entry(input string name, input board_t b, input logic black,
			input logic [31:0] count, input logic [31:0] sum);
		names_q.push_back(name);
		table_q.push_back('{board: b, black: black, count: count, sum: sum});
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		logic [31:0] got_count;
		logic [31:0] got_sum;
		logic finished;
		e = table_q[idx];
		got_count = 0;
		got_sum = 0;
		finished = 1'b0;
		@(posedge clk);
		board <= e.board;
		black_to_move <= e.black;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// odd entries hold the reader off so the output queue backs up
		if (idx % 2 == 1)
			repeat (pause_cycles) @(posedge clk);
		rden <= 1'b1;
		while (!finished) begin
			@(negedge clk);
			if (done && !move_valid)
				finished = 1'b1;
			else if (move_valid) begin
				assert ((7'(move_out.flags) & 7'h7e) == '0)
					else fail_run($sformatf("error %s flags expected %07b actual %07b",
						names_q[idx], 7'(move_out.flags) & 7'h01, 7'(move_out.flags)));
				assert (move_out.from.file == move_out.to.file)
					else fail_run($sformatf("error %s to file expected %0d actual %0d",
						names_q[idx], move_out.from.file, move_out.to.file));
				got_count++;
				got_sum += 32'(move_out);
			end
		end
		@(posedge clk);
		rden <= 1'b0;
		assert (got_count == e.count)
			else fail_run($sformatf("error %s count expected %0d actual %0d",
				names_q[idx], e.count, got_count));
		assert (got_sum == e.sum)
			else fail_run($sformatf("error %s sum expected %0d actual %0d",
				names_q[idx], e.sum, got_sum));
	endtask

	initial begin
		board_t b;
		logic side;
		logic [31:0] cnt;
		logic [31:0] sum;
		seed = 32'hdf224eca;
		reset = 1'b1;
		board = '0;
		black_to_move = 1'b0;
		start = 1'b0;
		rden = 1'b0;

		b = '0;
		add_entry("empty_board", b, 1'b0, 0, 0);
		b[24] = '{black: 1'b0, kind: `PC_ROOK};
		add_entry("lone_rook_a4", b, 1'b0, 7, 10952);

		// e4 rook between own knight on e6 and enemy pawn on e2
		b = '0;
		b[28] = '{black: 1'b0, kind: `PC_ROOK};
		b[44] = '{black: 1'b0, kind: pc_knight};
		b[12] = '{black: 1'b1, kind: pc_pawn};
		add_entry("boxed_rook", b, 1'b0, 3, 9540);

		b = '0;
		b[63] = '{black: 1'b1, kind: `PC_ROOK};
		b[7] = '{black: 1'b0, kind: pc_knight};
		b[2] = '{black: 1'b0, kind: pc_king};
		b[51] = '{black: 1'b1, kind: pc_pawn};
		add_entry("passive_white", b, 1'b0, 0, 0);
		add_entry("passive_black", b, 1'b1, 7, 32537);

		// twelve moves per file overflow the output queue
		b = '0;
		for (int f = 0; f < `FILES; f++) begin
			b[f] = '{black: 1'b0, kind: `PC_ROOK};
			b[56 + f] = '{black: 1'b0, kind: `PC_ROOK};
		end
		model(b, 1'b0, cnt, sum);
		add_entry("full_ranks", b, 1'b0, 96, sum);

		for (int k = 0; k < n_random; k++) begin
			b = random_board();
			seed = xorshift(seed);
			side = seed[0];
			model(b, side, cnt, sum);
			add_entry($sformatf("random_%0d", k), b, side, cnt, sum);
		end

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		if (i_move_gen_top.i_sva.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else
			fail_run("a bound assertion on the DUT failed");
	end

endmodule

// File: tb/move_gen_sva.sv
`include "move_gen_consts.svh"

module move_gen_sva (
	input logic clk,
	input logic reset,
	input logic done,
	input logic move_valid,
	input logic out_push,
	input logic out_full,
	input logic [`FILES-1:0] file_pop
);

	int fail_count = 0;

	// outputs come out of reset low
	reset_clears_outputs: assert property (
		@(posedge clk) reset |=> !done && !move_valid
	) else begin
		$error("done or move_valid high in the cycle after reset");
		fail_count++;
	end

	no_push_when_full: assert property (
		@(posedge clk) disable iff (reset) !(out_push && out_full)
	) else begin
		$error("collector pushed into a full output queue");
		fail_count++;
	end

	single_file_pop: assert property (
		@(posedge clk) disable iff (reset) $onehot0(file_pop)
	) else begin
		$error("more than one file queue popped in one cycle");
		fail_count++;
	end

endmodule

bind move_gen_top move_gen_sva i_sva (
	.clk(clk),
	.reset(reset),
	.done(done),
	.move_valid(move_valid),
	.out_push(out_push),
	.out_full(out_full),
	.file_pop(file_pop)
);

// File: design/move_gen_top.sv
`include "move_gen_consts.svh"

module move_gen_top import move_gen_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  board_t board,
	input  logic black_to_move,
	input  logic start,
	output move_t move_out,
	output logic move_valid,
	input  logic rden,
	output logic done
);

	logic [`FILES-1:0] scan_done;
	logic [`FILES-1:0] file_push;
	logic [`FILES-1:0] file_pop;
	logic [`FILES-1:0] file_empty;
	logic [`FILES-1:0] file_full;
	file_move_t [`FILES-1:0] file_push_data;
	file_move_t [`FILES-1:0] file_heads;

	logic out_push;
	logic out_empty;
	logic out_full;
	move_t out_data;

	// one scanner and one queue per file
	for (genvar f = 0; f < `FILES; f++) begin : g_file
		column_scanner #(
			.file_index(f)
		) i_scanner (
			.clk(clk),
			.reset(reset),
			.start(start),
			.board(board),
			.black_to_move(black_to_move),
			.q_full(file_full[f]),
			.push(file_push[f]),
			.push_data(file_push_data[f]),
			.scan_done(scan_done[f])
		);

		move_fifo #(
			.payload_t(file_move_t),
			.depth(`FILE_Q_DEPTH)
		) i_file_q (
			.clk(clk),
			.reset(reset),
			.push(file_push[f]),
			.push_data(file_push_data[f]),
			.pop(file_pop[f]),
			.head(file_heads[f]),
			.empty(file_empty[f]),
			.full(file_full[f])
		);
	end

	move_collector i_collector (
		.clk(clk),
		.reset(reset),
		.start(start),
		.scan_done(scan_done),
		.file_empty(file_empty),
		.file_heads(file_heads),
		.out_full(out_full),
		.file_pop(file_pop),
		.out_push(out_push),
		.out_data(out_data),
		.done(done)
	);

	// output queue, read side driven by rden
	move_fifo #(
		.payload_t(move_t),
		.depth(`OUT_Q_DEPTH)
	) i_out_q (
		.clk(clk),
		.reset(reset),
		.push(out_push),
		.push_data(out_data),
		.pop(rden),
		.head(move_out),
		.empty(out_empty),
		.full(out_full)
	);

	assign move_valid = ~out_empty;

endmodule

// File: design/move_collector.sv
`include "move_gen_consts.svh"

module move_collector import move_gen_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [`FILES-1:0] scan_done,
	input  logic [`FILES-1:0] file_empty,
	input  file_move_t [`FILES-1:0] file_heads,
	input  logic out_full,
	output logic [`FILES-1:0] file_pop,
	output logic out_push,
	output move_t out_data,
	output logic done
);

	collect_state_t state;
	logic [`FILES-1:0] collected;
	logic [`COORD_W-1:0] sel;

	logic [`FILES-1:0] ready;
	logic [`COORD_W-1:0] pick;
	file_move_t head;
	logic [$bits(move_flags_t)-1:0] flag_bits;
	logic transfer;

	// finished files still waiting to be drained
	assign ready = scan_done & ~collected;

	// lowest index wins
	always_comb begin
		pick = '0;
		for (int i = `FILES - 1; i >= 0; i--) begin
			if (ready[i])
				pick = `COORD_W'(i);
		end
	end

	assign head = file_heads[sel];

	// one entry per cycle, stall on empty file or full output
	assign transfer = (state == st_get_moves) && !file_empty[sel] && !out_full;
	assign out_push = transfer;
	assign file_pop = transfer ? `FILES'(1) << sel : '0;

	always_comb begin
		flag_bits = '0;
		flag_bits[`FLAG_CAPTURE] = head.capture;
		out_data.flags = move_flags_t'(flag_bits);
		out_data.from.rank = head.from_rank;
		out_data.from.file = sel;
		out_data.to.rank = head.to_rank;
		out_data.to.file = sel;
	end

	assign done = state == st_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			collected <= '0;
			sel <= '0;
		end else if (start) begin
			state <= st_wait_file;
			collected <= '0;
		end else begin
			case (state)
				st_wait_file: begin
					if (&collected)
						state <= st_done;
					else if (|ready) begin
						state <= st_get_moves;
						sel <= pick;
					end
				end
				st_get_moves: begin
					// queue drained, file finished
					if (file_empty[sel]) begin
						collected[sel] <= 1'b1;
						state <= st_wait_file;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: design/column_scanner.sv
`include "move_gen_consts.svh"

module column_scanner import move_gen_pkg::*; #(
	parameter int file_index = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  board_t board,
	input  logic black_to_move,
	input  logic q_full,
	output logic push,
	output file_move_t push_data,
	output logic scan_done
);

	typedef enum logic [1:0] {
		sc_idle,
		sc_find,
		sc_up,
		sc_down
	} scan_state_t;

	localparam logic [`COORD_W-1:0] last_rank = `COORD_W'(`RANKS - 1);

	scan_state_t state;
	scan_state_t state_n;
	piece_t [`RANKS-1:0] col;
	logic mover;
	logic [`COORD_W-1:0] from_rank;
	logic [`COORD_W-1:0] from_n;
	logic [`COORD_W-1:0] to_rank;
	logic [`COORD_W-1:0] to_n;

	piece_t from_sq;
	piece_t to_sq;
	logic slider;
	logic to_empty;
	logic to_enemy;
	logic stepping;
	logic hold;
	logic next_from;
	logic finish;

	// file squares and side to move, latched on start
	always_ff @(posedge clk) begin
		if (start) begin
			mover <= black_to_move;
			for (int r = 0; r < `RANKS; r++) begin
				col[r] <= board[r * `FILES + file_index];
			end
		end
	end

	assign from_sq = col[from_rank];
	assign to_sq = col[to_rank];

	// rook or queen of the mover
	assign slider = (from_sq.kind inside {`PC_ROOK, `PC_QUEEN}) && (from_sq.black == mover);
	assign to_empty = to_sq.kind == `PC_EMPTY;
	assign to_enemy = !to_empty && (to_sq.black != mover);

	assign stepping = (state == sc_up) || (state == sc_down);
	assign hold = stepping && q_full;

	// own piece gives no move
	assign push = stepping && !q_full && (to_empty || to_enemy);
	assign push_data = '{from_rank: from_rank, to_rank: to_rank, capture: to_enemy};

	always_comb begin
		state_n = state;
		from_n = from_rank;
		to_n = to_rank;
		next_from = 1'b0;
		finish = 1'b0;
		case (state)
			sc_find: begin
				if (!slider)
					next_from = 1'b1;
				else if (from_rank != last_rank) begin
					state_n = sc_up;
					to_n = from_rank + 1'b1;
				end else begin
					state_n = sc_down;
					to_n = from_rank - 1'b1;
				end
			end
			sc_up: begin
				// keep sliding only over empty squares
				if (to_empty && (to_rank != last_rank))
					to_n = to_rank + 1'b1;
				else if (from_rank != '0) begin
					state_n = sc_down;
					to_n = from_rank - 1'b1;
				end else
					next_from = 1'b1;
			end
			sc_down: begin
				if (to_empty && (to_rank != '0))
					to_n = to_rank - 1'b1;
				else
					next_from = 1'b1;
			end
			default: ;
		endcase

		// advance to next rank or wrap up the file
		if (next_from) begin
			if (from_rank == last_rank) begin
				state_n = sc_idle;
				finish = 1'b1;
			end else begin
				state_n = sc_find;
				from_n = from_rank + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sc_idle;
			scan_done <= 1'b0;
			from_rank <= '0;
			to_rank <= '0;
		end else if (start) begin
			state <= sc_find;
			scan_done <= 1'b0;
			from_rank <= '0;
		end else if (!hold) begin
			state <= state_n;
			from_rank <= from_n;
			to_rank <= to_n;
			if (finish)
				scan_done <= 1'b1;
		end
	end

endmodule

// File: design/move_fifo.sv
`include "move_gen_consts.svh"

module move_fifo import move_gen_pkg::*; #(
	parameter type payload_t = file_move_t,
	parameter int depth = `FILE_Q_DEPTH
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  payload_t push_data,
	input  logic pop,
	output payload_t head,
	output logic empty,
	output logic full
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == cnt_w'(depth);

	// push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: design/move_gen_pkg.sv
`include "move_gen_consts.svh"

package move_gen_pkg;

	// kind sits right under the colour bit
	typedef struct packed {
		logic black;
		logic [`COLOR_BIT-1:0] kind;
	} piece_t;

	// index is rank * 8 + file
	typedef struct packed {
		logic [`COORD_W-1:0] rank;
		logic [`COORD_W-1:0] file;
	} square_t;

	// square n at bits 4n+3 down to 4n
	typedef piece_t [`BOARD_W/`PIECE_W-1:0] board_t;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_two;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	// output word, flags over from over to
	typedef struct packed {
		move_flags_t flags;
		square_t from;
		square_t to;
	} move_t;

	// file queue entry, the file itself is implied by the queue
	typedef struct packed {
		logic [`COORD_W-1:0] from_rank;
		logic [`COORD_W-1:0] to_rank;
		logic capture;
	} file_move_t;

	typedef enum logic [1:0] {
		st_idle,
		st_wait_file,
		st_get_moves,
		st_done
	} collect_state_t;

endpackage

// File: design/move_gen_consts.svh
`ifndef MOVE_GEN_CONSTS_SVH
`define MOVE_GEN_CONSTS_SVH

// board geometry
`define FILES 8
`define RANKS 8
`define COORD_W 3

// one square is a colour bit over a piece kind
`define PIECE_W 4
`define COLOR_BIT 3
`define BOARD_W 256

// piece kinds, only the file sliders matter here
`define PC_EMPTY 3'd0
`define PC_ROOK 3'd4
`define PC_QUEEN 3'd5

// capture position in the 7 bit flag field
`define FLAG_CAPTURE 0

// queue depths in entries
`define FILE_Q_DEPTH 16
`define OUT_Q_DEPTH 64

`endif
